// File: filelist.f
+incdir+source
+incdir+test
source/dodgeGamePkg.sv
source/dodgeDisplayPkg.sv
source/tickGen.sv
source/playerCtrl.sv
source/dropSequencer.sv
source/collisionJudge.sv
source/spriteRom.sv
source/matrixScan.sv
source/dodgeTop.sv
test/dodgeTb.sv

// File: run.sh
#!/bin/sh
# build and run the dodge testbench, the log decides the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dodgeTb \
	-f filelist.f -o dodgeSim || { echo "build failed"; exit 1; }
./obj_dir/dodgeSim > sim.log 2>&1
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "simulation ended early"; exit 1; }
echo "simulation passed"

// File: test/dodgeModel.svh
`ifndef DODGE_MODEL_SVH
`define DODGE_MODEL_SVH

// ============================================================
// reference state, advanced on every rising edge
// ============================================================
int unsigned mCyc;  // edges since reset release
int mRow;
int mCoins;
logic mHit;
logic [3:0] mTaken;
dodgeGamePkg::place_t mPlace;
dodgeGamePkg::step_t mStep;
logic [7:0] mSeg;
logic [`DODGE_BAR_W-1:0] mBar;
logic [3:0] mComm;
logic [7:0] mRed;
logic [7:0] mGreen;
logic [7:0] mBlue;
logic modelValid = 1'b0;

// columns where the falling obstacle meets the bottom row
function automatic logic hitAt(int step, int place);
	case (step)
		7: return place >= 3 && place <= 5;
		10: return place >= 5 && place <= 7;
		14: return place >= 1 && place <= 3;
		15: return place <= 2;
		default: return 1'b0;
	endcase
endfunction

function automatic int coinAt(int step, int place);
	if (step == 8 && place == 2)
		return 0;
	if (step == 9 && place == 5)
		return 1;
	if (step == 11 && place == 3)
		return 2;
	if (step == 14 && place == 6)
		return 3;
	return -1;
endfunction

task automatic resetModel();
	mCyc = 0;
	mRow = 0;
	mCoins = 0;
	mHit = 1'b0;
	mTaken = '0;
	mPlace = 4'd3;
	mStep = 5'd0;
	mSeg = dodgeDisplayPkg::SEG_DIGIT[0];
	mBar = '1;
	mComm = 4'b0001;
	mRed = 8'hFF;
	mGreen = 8'hFF;
	mBlue = 8'hFF;
	modelValid = 1'b1;
endtask

// every state update reads the values from before the edge
task automatic advanceModel(input logic inLeft, input logic inRight);
	logic scanT;
	logic moveT;
	logic stepT;
	logic hitNext;
	int coin;
	dodgeDisplayPkg::frame_u frame;
	scanT = mCyc > 0 && mCyc % SCAN_DIV == 0;
	moveT = mCyc > 0 && mCyc % MOVE_DIV == 0;
	stepT = mCyc > 0 && mCyc % STEP_DIV == 0;
	hitNext = mHit || hitAt(mStep, mPlace);
	coin = coinAt(mStep, mPlace);
	mSeg = dodgeDisplayPkg::SEG_DIGIT[mCoins];
	if (scanT)
	begin
		mComm = {mRow[2:0], 1'b1};
		mRed = 8'hFF;
		if (mPlace != 4'd8 && mRow == int'(dodgeDisplayPkg::PLAYER_ROW[mPlace[2:0]]))
			mRed[7] = 1'b0;
		frame = dodgeDisplayPkg::GREEN_FRAMES[mStep];
		mGreen = frame.flat[mRow*8 +: 8];
		mBlue = 8'hFF;
		if (mStep >= 1 && mStep <= 15)
		begin
			frame = dodgeDisplayPkg::BLUE_FRAMES[mStep];
			mBlue = frame.flat[mRow*8 +: 8];
		end
		mRow = (mRow + 1) % 8;
	end
	if (moveT)
	begin
		if (mHit || mStep == 5'd17)
			mPlace = 4'd8;  // player leaves the board
		else if (inLeft && mPlace < 4'd7)
			mPlace = mPlace + 4'd1;
		else if (!inLeft && inRight && mPlace > 4'd0)
			mPlace = mPlace - 4'd1;
	end
	if (stepT)
	begin
		if (mHit)
		begin
			mStep = 5'd18;
			mBar = '0;
		end
		else
		begin
			if (mStep < 5'd17)
				mStep = mStep + 5'd1;
			mBar = mBar >> 1;
		end
	end
	mHit = hitNext;
	if (coin >= 0 && !mTaken[coin])
	begin
		mTaken[coin] = 1'b1;
		mCoins++;
	end
	mCyc++;
endtask

`endif

// File: test/dodgeTb.sv
`timescale 1ns/1ps
`include "dodge_params.svh"

module dodgeTb;

	localparam int SCAN_DIV = 3;
	localparam int MOVE_DIV = 5;
	localparam int STEP_DIV = 40;
	localparam int GAMES = 6;
	localparam int CYCLE_LIMIT = GAMES * 20 * STEP_DIV + 2000;
	localparam int NOISE [GAMES] = '{0, 3, 6, 10, 13, 16};  // out of 16

	logic CLK;
	logic rstN = 1'b0;
	logic left = 1'b0;
	logic right = 1'b0;
	logic [`DODGE_ROWS-1:0] red;
	logic [`DODGE_ROWS-1:0] green;
	logic [`DODGE_ROWS-1:0] blue;
	logic [3:0] comm;
	logic [7:0] sevenSeg;
	logic [`DODGE_BAR_W-1:0] timeBar;

	logic [31:0] rng = 32'd24986;
	logic driving = 1'b0;
	logic nextLeft = 1'b0;
	logic nextRight = 1'b0;
	int holdLeft = 0;
	int noise = 0;
	int errors = 0;
	int cycles = 0;

	`include "dodgeModel.svh"

	dodgeTop #(
		.SCAN_DIV (SCAN_DIV),
		.MOVE_DIV (MOVE_DIV),
		.STEP_DIV (STEP_DIV)
	) dut_i (
		.CLK      (CLK),
		.rstN     (rstN),
		.left     (left),
		.right    (right),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.comm     (comm),
		.sevenSeg (sevenSeg),
		.timeBar  (timeBar)
	);

	initial
	begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// safe column per step, coins at steps 8, 11 and 14 on the way
	function automatic int guideTarget(int step);
		case (step)
			0, 1, 2, 3, 4, 5, 6, 7: return 1;
			8: return 2;
			9: return 4;
			10, 11: return 3;
			default: return 6;
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s got %0h expected %0h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic pickInputs();
		int target;
		if (holdLeft > 0)
			holdLeft--;
		else
		begin
			rng = xorshift(rng);
			target = guideTarget(mStep);
			if (int'(rng[7:4]) < noise)
			begin
				nextLeft = rng[8];
				nextRight = rng[9];
				holdLeft = rng[12:10];
			end
			else
			begin
				nextLeft = mPlace < target;
				nextRight = mPlace > target;
				holdLeft = rng[1:0];  // short enough for one move at most
			end
		end
	endtask

	task applyReset();
		@(posedge CLK);
		rstN <= 1'b0;
		repeat (16) @(posedge CLK);
		rstN <= 1'b1;
		@(negedge CLK);
	endtask

	// model first, then the inputs for the next edge
	always @(posedge CLK)
	begin
		if (!rstN)
			resetModel();
		else
			advanceModel(left, right);
		if (driving)
			pickInputs();
		else
		begin
			nextLeft = 1'b0;
			nextRight = 1'b0;
			holdLeft = 0;
		end
		left <= nextLeft;
		right <= nextRight;
	end

	always @(negedge CLK)
	begin
		if (modelValid)
		begin
			compareValue("red", red, mRed);
			compareValue("green", green, mGreen);
			compareValue("blue", blue, mBlue);
			compareValue("comm", comm, mComm);
			compareValue("sevenSeg", sevenSeg, mSeg);
			compareValue("timeBar", timeBar, mBar);
		end
	end

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("timeout: games did not end within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ============================================================
	// games
	// ============================================================
	initial
	begin
		int startErrors;
		int passed;
		int failed;
		int wins;
		int losses;
		dodgeDisplayPkg::frame_u endFrame;
		passed = 0;
		failed = 0;
		wins = 0;
		losses = 0;
		for (int g = 0; g < GAMES; g++)
		begin
			startErrors = errors;
			noise = NOISE[g];
			applyReset();
			compareValue("timeBar", timeBar, {`DODGE_BAR_W{1'b1}});
			compareValue("sevenSeg", sevenSeg, dodgeDisplayPkg::SEG_DIGIT[0]);
			compareValue("red", red, 8'hFF);
			compareValue("green", green, 8'hFF);
			compareValue("blue", blue, 8'hFF);
			compareValue("comm", comm, 4'b0001);
			driving = 1'b1;
			while (!(timeBar === '0 && mStep >= 5'd17 && mPlace == 4'd8))
				@(negedge CLK);
			repeat (8 * SCAN_DIV) @(negedge CLK);  // one full frame
			driving = 1'b0;
			endFrame = dodgeDisplayPkg::GREEN_FRAMES[mHit ? 18 : 17];  // cross or circle
			compareValue("green", green, endFrame.flat[comm[3:1]*8 +: 8]);
			compareValue("red", red, 8'hFF);
			compareValue("timeBar", timeBar, '0);
			compareValue("sevenSeg", sevenSeg, dodgeDisplayPkg::SEG_DIGIT[mCoins]);
			if (mHit)
				losses++;
			else
				wins++;
			if (errors == startErrors)
				passed++;
			else
				failed++;
			$display("game %0d noise %0d: %s with %0d coins, %0d errors", g, noise,
				mHit ? "hit" : "win", mCoins, errors - startErrors);
		end
		if (wins == 0 || losses == 0)
		begin
			$display("the games did not include both a win and a hit");
			errors++;
		end
		$display("%0d games, %0d passed, %0d failed, %0d wins, %0d hits, %0d errors",
			GAMES, passed, failed, wins, losses, errors);
		if (failed == 0 && errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: source/dodgeTop.sv
`timescale 1ns/1ps
`include "dodge_params.svh"

module dodgeTop #(
	parameter int SCAN_DIV = `DODGE_SCAN_DIV,
	parameter int MOVE_DIV = `DODGE_MOVE_DIV,
	parameter int STEP_DIV = `DODGE_STEP_DIV
) (
	input  logic                    CLK,
	input  logic                    rstN,
	input  logic                    left,
	input  logic                    right,
	output logic [`DODGE_ROWS-1:0]  red,
	output logic [`DODGE_ROWS-1:0]  green,
	output logic [`DODGE_ROWS-1:0]  blue,
	output logic [3:0]              comm,
	output logic [7:0]              sevenSeg,
	output logic [`DODGE_BAR_W-1:0] timeBar
);

	logic scanTick;
	logic moveTick;
	logic stepTick;
	logic hit;
	dodgeGamePkg::step_t step;
	dodgeGamePkg::place_t place;

	tickGen #(
		.SCAN_DIV (SCAN_DIV),
		.MOVE_DIV (MOVE_DIV),
		.STEP_DIV (STEP_DIV)
	) tick_i (
		.CLK      (CLK),
		.rstN     (rstN),
		.scanTick (scanTick),
		.moveTick (moveTick),
		.stepTick (stepTick)
	);

	playerCtrl player_i (.CLK(CLK), .rstN(rstN), .moveTick(moveTick), .left(left),
		.right(right), .hit(hit), .step(step), .place(place));

	dropSequencer drop_i (.CLK(CLK), .rstN(rstN), .stepTick(stepTick), .hit(hit),
		.step(step), .timeBar(timeBar));

	collisionJudge judge_i (.CLK(CLK), .rstN(rstN), .step(step), .place(place),
		.hit(hit), .sevenSeg(sevenSeg));

	matrixScan scan_i (.CLK(CLK), .rstN(rstN), .scanTick(scanTick), .step(step),
		.place(place), .red(red), .green(green), .blue(blue), .comm(comm));

endmodule

// File: source/matrixScan.sv
`timescale 1ns/1ps
`include "dodge_params.svh"

module matrixScan (
	input  logic                   CLK,
	input  logic                   rstN,
	input  logic                   scanTick,
	input  dodgeGamePkg::step_t    step,
	input  dodgeGamePkg::place_t   place,
	output logic [`DODGE_ROWS-1:0] red,
	output logic [`DODGE_ROWS-1:0] green,
	output logic [`DODGE_ROWS-1:0] blue,
	output logic [3:0]             comm
);

	dodgeDisplayPkg::row_t rowCnt;
	logic [`DODGE_ROWS-1:0] greenRow;
	logic [`DODGE_ROWS-1:0] blueRow;
	logic [`DODGE_ROWS-1:0] redRow;

	spriteRom rom_i (
		.step     (step),
		.row      (rowCnt),
		.greenRow (greenRow),
		.blueRow  (blueRow)
	);

	// player dot sits in bit 7 of its mapped row
	always_comb
	begin
		redRow = '1;
		if (place != dodgeGamePkg::PLACE_GONE
			&& rowCnt == dodgeDisplayPkg::PLAYER_ROW[place[2:0]])
			redRow[`DODGE_ROWS-1] = 1'b0;
	end

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			rowCnt <= '0;
			comm <= 4'b0001;  // row 0
			red <= '1;
			green <= '1;
			blue <= '1;
		end
		else if (scanTick)
		begin
			comm <= {rowCnt, 1'b1};
			red <= redRow;
			green <= greenRow;
			blue <= blueRow;
			rowCnt <= rowCnt + 3'd1;  // wraps after row 7
		end
	end

endmodule

// File: source/spriteRom.sv
`timescale 1ns/1ps
`include "dodge_params.svh"

module spriteRom (
	input  dodgeGamePkg::step_t    step,
	input  dodgeDisplayPkg::row_t  row,
	output logic [`DODGE_ROWS-1:0] greenRow,
	output logic [`DODGE_ROWS-1:0] blueRow
);

	dodgeDisplayPkg::frame_u greenFrame;
	dodgeDisplayPkg::frame_u blueFrame;

	// ============================================================
	// obstacle frames
	// ============================================================
	always_comb
	begin
		if (step <= dodgeGamePkg::STEP_CROSS)
			greenFrame = dodgeDisplayPkg::GREEN_FRAMES[step];
		else
			greenFrame.flat = '1;  // dark
	end

	// ============================================================
	// coin frames
	// ============================================================
	always_comb
	begin
		if (step >= 5'd1 && step <= 5'd15)
			blueFrame = dodgeDisplayPkg::BLUE_FRAMES[step];
		else
			blueFrame.flat = '1;  // no coins before the first drop or after the last
	end

	assign greenRow = greenFrame.rows[row];
	assign blueRow = blueFrame.rows[row];

endmodule

// File: source/collisionJudge.sv
`timescale 1ns/1ps

module collisionJudge (
	input  logic                 CLK,
	input  logic                 rstN,
	input  dodgeGamePkg::step_t  step,
	input  dodgeGamePkg::place_t place,
	output logic                 hit,
	output logic [7:0]           sevenSeg
);

	logic [dodgeGamePkg::COIN_COUNT-1:0] taken;
	logic [dodgeGamePkg::COIN_COUNT-1:0] coinNew;
	dodgeGamePkg::score_t score;

	// each coin step pays out once
	always_comb
	begin
		for (int i = 0; i < dodgeGamePkg::COIN_COUNT; i++)
			coinNew[i] = !taken[i] && step == dodgeGamePkg::COIN_STEP[i]
				&& place == dodgeGamePkg::COIN_PLACE[i];
	end

	// ============================================================
	// hit, coins, score
	// ============================================================
	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			hit <= 1'b0;
			taken <= '0;
			score <= '0;
		end
		else
		begin
			if (dodgeGamePkg::hitRule(step, place))
				hit <= 1'b1;  // sticky until reset
			taken <= taken | coinNew;
			if (|coinNew)
				score <= score + 3'd1;  // coin steps never overlap
		end
	end

	// display follows the count a cycle later
	always_ff @(posedge CLK)
	begin
		if (!rstN)
			sevenSeg <= dodgeDisplayPkg::SEG_DIGIT[0];
		else
			sevenSeg <= dodgeDisplayPkg::SEG_DIGIT[score];
	end

	scoreRange: assert property (@(posedge CLK) disable iff (!rstN)
		score <= dodgeGamePkg::SCORE_MAX);

endmodule

// File: source/dropSequencer.sv
`timescale 1ns/1ps
`include "dodge_params.svh"

module dropSequencer (
	input  logic                    CLK,
	input  logic                    rstN,
	input  logic                    stepTick,
	input  logic                    hit,
	output dodgeGamePkg::step_t     step,
	output logic [`DODGE_BAR_W-1:0] timeBar
);

	always_ff @(posedge CLK)
	begin
		if (!rstN)
		begin
			step <= '0;
			timeBar <= '1;  // full bar
		end
		else if (stepTick)
		begin
			if (hit)
			begin
				step <= dodgeGamePkg::STEP_CROSS;
				timeBar <= '0;
			end
			else
			begin
				if (step < dodgeGamePkg::STEP_WIN)
					step <= step + 5'd1;
				timeBar <= {1'b0, timeBar[`DODGE_BAR_W-1:1]};  // drain from the top
			end
		end
	end

	stepRange: assert property (@(posedge CLK) disable iff (!rstN)
		step <= dodgeGamePkg::STEP_CROSS);

endmodule

// File: source/playerCtrl.sv
`timescale 1ns/1ps

module playerCtrl (
	input  logic                 CLK,
	input  logic                 rstN,
	input  logic                 moveTick,
	input  logic                 left,
	input  logic                 right,
	input  logic                 hit,
	input  dodgeGamePkg::step_t  step,
	output dodgeGamePkg::place_t place
);

	always_ff @(posedge CLK)
	begin
		if (!rstN)
			place <= dodgeGamePkg::PLACE_START;
		else if (moveTick)
		begin
			if (hit || step == dodgeGamePkg::STEP_WIN)
				place <= dodgeGamePkg::PLACE_GONE;  // game over either way
			else if (left)
			begin
				if (place < 4'd7)
					place <= place + 4'd1;
			end
			else if (right)
			begin
				if (place > 4'd0)
					place <= place - 4'd1;
			end
		end
	end

	placeRange: assert property (@(posedge CLK) disable iff (!rstN)
		place <= dodgeGamePkg::PLACE_GONE);

endmodule

// File: source/tickGen.sv
`timescale 1ns/1ps
`include "dodge_params.svh"

module tickGen #(
	parameter int SCAN_DIV = `DODGE_SCAN_DIV,
	parameter int MOVE_DIV = `DODGE_MOVE_DIV,
	parameter int STEP_DIV = `DODGE_STEP_DIV
) (
	input  logic CLK,
	input  logic rstN,
	output logic scanTick,
	output logic moveTick,
	output logic stepTick
);

	localparam int DIVS [3] = '{SCAN_DIV, MOVE_DIV, STEP_DIV};

	logic [2:0] ticks;

	for (genvar i = 0; i < 3; i++)
	begin : genDiv
		localparam int CW = (DIVS[i] > 1) ? $clog2(DIVS[i]) : 1;
		localparam logic [CW-1:0] LAST = CW'(DIVS[i] - 1);

		logic [CW-1:0] count;
		logic pulse;

		always_ff @(posedge CLK)
		begin
			if (!rstN)
			begin
				count <= '0;
				pulse <= 1'b0;
			end
			else
			begin
				pulse <= (count == LAST);  // one cycle per wrap
				count <= (count == LAST) ? '0 : count + 1'b1;
			end
		end

		assign ticks[i] = pulse;
	end

	assign scanTick = ticks[0];
	assign moveTick = ticks[1];
	assign stepTick = ticks[2];

endmodule

// File: source/dodgeDisplayPkg.sv
`include "dodge_params.svh"

package dodgeDisplayPkg;

	typedef logic [$clog2(`DODGE_ROWS)-1:0] row_t;

	// one frame word, stored flat, scanned row by row (active low)
	typedef union packed
	{
		logic [`DODGE_ROWS*`DODGE_ROWS-1:0] flat;
		logic [`DODGE_ROWS-1:0][`DODGE_ROWS-1:0] rows;
	} frame_u;

	// ============================================================
	// seven-segment codes and player rows
	// ============================================================
	localparam logic [7:0] SEG_DIGIT [5] = '{8'b0000_0010, 8'b1001_1110, 8'b0010_0100,
		8'b0000_1100, 8'b1001_1000};

	// scan row whose bit 7 marks each player column
	localparam row_t PLAYER_ROW [8] = '{3'd7, 3'd3, 3'd5, 3'd1, 3'd6, 3'd2, 3'd4, 3'd0};

	// ============================================================
	// frames, top byte is row 7
	// ============================================================
	localparam frame_u GREEN_FRAMES [19] = '{
		64'hFFFE_FFFF_FFFE_FEFF, 64'hFFFD_FFFF_FFFD_FDFF, 64'hFFFB_FFFF_FFFB_FBFF,
		64'hFFF7_FFFE_FFF6_F7FE, 64'hFFEF_FFFD_FFED_EFFD, 64'hFFDF_FFFB_FFDB_DFFB,
		64'hFFBF_FEF7_FEB7_BEF7, 64'hFF7F_FDEF_FD6F_7DEF, 64'hFEFF_FADF_FADF_FBDF,
		64'hFDFF_F5BF_F5BF_F7BF, 64'hFBFF_EB7F_EB7F_EF7F, 64'hF7FF_D7FF_D7FF_DFFF,
		64'hEFFF_AFFF_AFFF_BFFF, 64'hDFFF_5FFF_5FFF_7FFF, 64'hBFFF_BFFF_BFFF_FFFF,
		64'h7FFF_7FFF_7FFF_FFFF, 64'hFFFF_FFFF_FFFF_FFFF,
		64'hE07F_BFDF_DFBF_7FE0,  // circle
		64'h7EE7_DBBD_BDDB_E77E   // cross
	};

	localparam frame_u BLUE_FRAMES [1:15] = '{
		64'hFFFF_FEFF_FFFE_FFFF, 64'hFFFF_FDFF_FFFE_FFFF, 64'hFFFF_FBFF_FFFD_FFFF,
		64'hFFFF_F7FF_FFFB_FEFF, 64'hFFFF_EFFF_FFF7_FDFF, 64'hFFFF_DFFF_FFEF_FBFF,
		64'hFFFF_BFFE_FFDF_F7FF, 64'hFFFF_7FFD_FFBF_EFFF, 64'hFFFF_FFFB_FF7F_DFFF,
		64'hFFFF_FFF7_FFFF_BFFF, 64'hFFFF_FFEF_FFFF_7FFF, 64'hFFFF_FFDF_FFFF_FFFF,
		64'hFFFF_FFBF_FFFF_FFFF, 64'hFFFF_FF7F_FFFF_FFFF,
		64'hFFFF_FFFF_FFFF_FFFF   // coins gone
	};

endpackage

// File: source/dodgeGamePkg.sv
package dodgeGamePkg;

	// ============================================================
	// game state
	// ============================================================
	typedef logic [3:0] place_t;  // 0..7 column, 8 gone
	typedef logic [4:0] step_t;   // 0..18
	typedef logic [2:0] score_t;  // coins collected

	localparam place_t PLACE_START = 4'd3;
	localparam place_t PLACE_GONE = 4'd8;
	localparam step_t STEP_WIN = 5'd17;    // circle frame
	localparam step_t STEP_CROSS = 5'd18;  // cross frame

	// ============================================================
	// hit and coin rules
	// ============================================================
	localparam int COIN_COUNT = 4;
	localparam score_t SCORE_MAX = 3'd4;
	localparam step_t COIN_STEP [COIN_COUNT] = '{5'd8, 5'd9, 5'd11, 5'd14};
	localparam place_t COIN_PLACE [COIN_COUNT] = '{4'd2, 4'd5, 4'd3, 4'd6};

	// obstacle reaches the bottom row on these steps
	function automatic logic hitRule(step_t step, place_t place);
		case (step)
			5'd7: hitRule = (place >= 4'd3) && (place <= 4'd5);
			5'd10: hitRule = (place >= 4'd5) && (place <= 4'd7);
			5'd14: hitRule = (place >= 4'd1) && (place <= 4'd3);
			5'd15: hitRule = (place <= 4'd2);
			default: hitRule = 1'b0;
		endcase
	endfunction

endpackage

// File: source/dodge_params.svh
`ifndef DODGE_PARAMS_SVH
`define DODGE_PARAMS_SVH

// ============================================================
// clock-enable dividers, in CLK cycles
// ============================================================
`define DODGE_SCAN_DIV 10000     // one matrix row per scan tick
`define DODGE_MOVE_DIV 3000000   // player move rate
`define DODGE_STEP_DIV 25000000  // obstacle drop rate

// ============================================================
// geometry
// ============================================================
`define DODGE_ROWS 8             // matrix is square
`define DODGE_BAR_W 16           // time bar LEDs

`endif
